//--- tb.f
hdl/pu_bus_pkg.sv
hdl/pu_pma_pkg.sv
hdl/pma_check.sv
hdl/wb_spram.sv
hdl/wb_pma_guard.sv
hdl/pu_mem_subsys.sv
dv/pu_mem_subsys_assertions.sv
dv/tb_pu_mem_subsys.sv

//--- Bender.yml
package:
  name: pu_mem_subsys

sources:
  - hdl/pu_bus_pkg.sv
  - hdl/pu_pma_pkg.sv
  - hdl/pma_check.sv
  - hdl/wb_spram.sv
  - hdl/wb_pma_guard.sv
  - hdl/pu_mem_subsys.sv
  - target: test
    files:
      - dv/pu_mem_subsys_assertions.sv
      - dv/tb_pu_mem_subsys.sv

//--- dv/tb_pu_mem_subsys.sv
/* Directed testbench for the memory subsystem. Plays the core's bus master on
 * both ports and checks every response against shadow RAMs and the region map.
 */

`default_nettype none

module tb_pu_mem_subsys;

  timeunit 1ns;
  timeprecision 1ps;

  import pu_bus_pkg::*;

  localparam int DEPTH = 256;
  localparam int INS   = 0;
  localparam int DAT   = 1;
  // Cycle budget is twice the summed test length
  localparam int RESET_CYC   = 10;
  localparam int ACCESS_CYC  = 3;
  localparam int N_ACCESS    = 63;
  localparam int BURST_CYC   = 10;
  localparam int N_BURST     = 4;
  localparam int CYCLE_LIMIT = 2 * (RESET_CYC + ACCESS_CYC * N_ACCESS + BURST_CYC * N_BURST);

  logic             hclk = 1'b0;
  logic             rst_n;
  // Master side indexed by INS or DAT
  logic [PLEN-1:0]  m_adr  [2];
  logic [XLEN-1:0]  m_wdat [2];
  logic [SEL_W-1:0] m_sel  [2];
  logic             m_we   [2];
  logic             m_cyc  [2];
  logic             m_stb  [2];
  logic [2:0]       m_cti  [2];
  logic [1:0]       m_bte  [2];
  logic [XLEN-1:0]  ins_rdat;
  logic [XLEN-1:0]  dat_rdat;
  logic             ins_ack;
  logic             ins_err;
  logic             dat_ack;
  logic             dat_err;
  // Record of each beat of the last access
  logic [PLEN-1:0]  beat_adr  [16];
  logic [XLEN-1:0]  beat_wdat [16];
  logic [XLEN-1:0]  beat_rdat [16];
  logic             beat_ack  [16];
  logic             beat_err  [16];
  int               beat_lat  [16];
  // Shadow RAMs start cleared like the DUT
  logic [XLEN-1:0]  shadow [2][DEPTH] = '{default: '0};
  int               n_checks;
  int               n_errors;
  int               n_asserts;
  int               cycle_cnt;
  integer           seed;

  always #5 hclk = ~hclk;

  pu_mem_subsys #(
    .DEPTH ( DEPTH )
  ) dut0 (
    .hclk_i    ( hclk        ),
    .rst_n_i   ( rst_n       ),
    .ins_adr_i ( m_adr[INS]  ),
    .ins_dat_i ( m_wdat[INS] ),
    .ins_sel_i ( m_sel[INS]  ),
    .ins_we_i  ( m_we[INS]   ),
    .ins_cyc_i ( m_cyc[INS]  ),
    .ins_stb_i ( m_stb[INS]  ),
    .ins_cti_i ( m_cti[INS]  ),
    .ins_bte_i ( m_bte[INS]  ),
    .ins_dat_o ( ins_rdat    ),
    .ins_ack_o ( ins_ack     ),
    .ins_err_o ( ins_err     ),
    .dat_adr_i ( m_adr[DAT]  ),
    .dat_dat_i ( m_wdat[DAT] ),
    .dat_sel_i ( m_sel[DAT]  ),
    .dat_we_i  ( m_we[DAT]   ),
    .dat_cyc_i ( m_cyc[DAT]  ),
    .dat_stb_i ( m_stb[DAT]  ),
    .dat_cti_i ( m_cti[DAT]  ),
    .dat_bte_i ( m_bte[DAT]  ),
    .dat_dat_o ( dat_rdat    ),
    .dat_ack_o ( dat_ack     ),
    .dat_err_o ( dat_err     )
  );

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // Region map as x r w per address range where the first hit wins
  function automatic logic access_allowed(input int port, input logic [PLEN-1:0] a,
                                          input logic we_v);
    logic [2:0] xrw;
    if (a < 32'h8000_0200) xrw = 3'b111;
    else if (a < 32'h8000_0210) xrw = 3'b011;
    else if (a < 32'h8000_0214) xrw = 3'b001;
    else if (a < 32'h8000_0400) xrw = 3'b011;
    else xrw = 3'b000;
    if (we_v) return xrw[0];
    return (port == INS) ? xrw[2] : xrw[1];
  endfunction

  // Old word with the selected byte lanes replaced
  function automatic logic [XLEN-1:0] merge_bytes(input logic [XLEN-1:0] old,
                                                  input logic [XLEN-1:0] wdat,
                                                  input logic [SEL_W-1:0] sel_v);
    logic [XLEN-1:0] res;
    res = old;
    for (int b = 0; b < SEL_W; b++) begin
      if (sel_v[b]) res[8*b +: 8] = wdat[8*b +: 8];
    end
    return res;
  endfunction

  // Byte address of the next beat wrapped inside a 16, 32 or 64 byte block
  function automatic logic [PLEN-1:0] next_beat_adr(input logic [PLEN-1:0] a,
                                                    input logic [1:0] bte_v);
    logic [PLEN-1:0] span;
    case (bte_v)
      BTE_WRAP4:  span = 16;
      BTE_WRAP8:  span = 32;
      BTE_WRAP16: span = 64;
      default:    span = 0;
    endcase
    if (span == 0) return a + 4;
    return (a & ~(span - 1)) | ((a + 4) & (span - 1));
  endfunction

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  task automatic compare_data(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                              input string msg);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Mismatch at %0t: %s data %h, expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic compare_resp(input logic got_ack, input logic got_err, input logic exp_ack,
                              input logic exp_err, input string msg);
    n_checks++;
    if ({got_ack, got_err} !== {exp_ack, exp_err}) begin
      n_errors++;
      $display("Mismatch at %0t: %s ack %b err %b, expected ack %b err %b",
               $time, msg, got_ack, got_err, exp_ack, exp_err);
    end
  endtask

  task automatic compare_latency(input int got, input int exp, input string msg);
    n_checks++;
    if (got != exp) begin
      n_errors++;
      $display("Mismatch at %0t: %s answered after %0d edges, expected %0d",
               $time, msg, got, exp);
    end
  endtask

  //////////////////////////////////////////////////
  // Bus master
  //////////////////////////////////////////////////

  // Runs all beats with CTI_INCR before the last and records each response
  task automatic wb_burst(input int port, input logic [PLEN-1:0] start, input logic [1:0] bte_v,
                          input int beats, input logic we_v, input logic [SEL_W-1:0] sel_v,
                          input logic [2:0] last_cti);
    logic [PLEN-1:0] a;
    a = start;
    @(posedge hclk);
    for (int i = 0; i < beats; i++) begin
      beat_adr[i] = a;
      m_adr[port]  <= a;
      m_wdat[port] <= beat_wdat[i];
      m_sel[port]  <= sel_v;
      m_we[port]   <= we_v;
      m_bte[port]  <= bte_v;
      m_cti[port]  <= (i == beats - 1) ? last_cti : CTI_INCR;
      m_cyc[port]  <= 1'b1;
      m_stb[port]  <= 1'b1;
      // Latency counted in falling edges mid cycle
      beat_lat[i] = 0;
      do begin
        @(negedge hclk);
        beat_lat[i]++;
        beat_ack[i] = (port == INS) ? ins_ack : dat_ack;
        beat_err[i] = (port == INS) ? ins_err : dat_err;
      end while (!beat_ack[i] && !beat_err[i]);
      beat_rdat[i] = (port == INS) ? ins_rdat : dat_rdat;
      a = next_beat_adr(a, bte_v);
      @(posedge hclk);
    end
    m_cyc[port] <= 1'b0;
    m_stb[port] <= 1'b0;
    m_we[port]  <= 1'b0;
  endtask

  // Response and latency of one recorded beat and then its data or shadow update
  task automatic check_beat(input int port, input int i, input logic we_v,
                            input logic [SEL_W-1:0] sel_v, input int exp_lat);
    logic  ok;
    int    idx;
    string where;
    ok    = access_allowed(port, beat_adr[i], we_v);
    idx   = (beat_adr[i] >> 2) % DEPTH;
    where = $sformatf("%s %s %h", (port == INS) ? "ins" : "dat", we_v ? "write" : "read",
                      beat_adr[i]);
    compare_resp(beat_ack[i], beat_err[i], ok, !ok, where);
    compare_latency(beat_lat[i], exp_lat, where);
    if (ok && we_v) shadow[port][idx] = merge_bytes(shadow[port][idx], beat_wdat[i], sel_v);
    else if (ok) compare_data(beat_rdat[i], shadow[port][idx], where);
  endtask

  // Classic cycle with the response one edge after the strobe is sampled
  task automatic wb_single(input int port, input logic [PLEN-1:0] a, input logic we_v,
                           input logic [SEL_W-1:0] sel_v, input logic [XLEN-1:0] wdat);
    beat_wdat[0] = wdat;
    wb_burst(port, a, BTE_LINEAR, 1, we_v, sel_v, CTI_CLASSIC);
    check_beat(port, 0, we_v, sel_v, 2);
  endtask

  task automatic check_burst(input int port, input int beats, input logic we_v);
    for (int i = 0; i < beats; i++) begin
      // Later beats must be acked back to back
      check_beat(port, i, we_v, 4'hf, (i == 0) ? 2 : 1);
    end
  endtask

  task automatic report_test(input string name, input int e0);
    $display("Test %s finished, %0d mismatches", name, n_errors - e0);
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic test_reset();
    int e0;
    e0 = n_errors;
    @(negedge hclk);
    compare_resp(ins_ack, ins_err, 1'b0, 1'b0, "ins port after reset");
    compare_resp(dat_ack, dat_err, 1'b0, 1'b0, "dat port after reset");
    wb_single(DAT, RAM_BASE, 1'b0, 4'hf, '0);
    wb_single(INS, RAM_BASE, 1'b0, 4'hf, '0);
    report_test("reset", e0);
  endtask

  task automatic test_byte_rw();
    int              e0;
    logic [PLEN-1:0] a;
    logic [XLEN-1:0] rnd;
    logic [PLEN-1:0] adrs [$];
    e0 = n_errors;
    for (int i = 0; i < 16; i++) begin
      // Half in region 0 and half in region 3 above the NA4 word
      if (i < 8) a = RAM_BASE + 4 * ($unsigned($random(seed)) % 128);
      else a = RAM_BASE + 4 * (133 + $unsigned($random(seed)) % 123);
      rnd = $random(seed);
      adrs.push_back(a);
      wb_single(DAT, a, 1'b1, rnd[3:0], $random(seed));
    end
    foreach (adrs[i]) wb_single(DAT, adrs[i], 1'b0, 4'hf, '0);
    report_test("byte_rw", e0);
  endtask

  task automatic test_perm();
    int e0;
    e0 = n_errors;
    // Region 2 is write only
    wb_single(DAT, 32'h8000_0210, 1'b1, 4'hf, $random(seed));
    wb_single(DAT, 32'h8000_0210, 1'b0, 4'hf, '0);
    // Region 1 allows read and write
    wb_single(DAT, 32'h8000_0204, 1'b1, 4'hf, $random(seed));
    wb_single(DAT, 32'h8000_0204, 1'b0, 4'hf, '0);
    // Known contents in words 0 and 1 that the addresses past the table alias
    wb_single(DAT, RAM_BASE, 1'b1, 4'hf, $random(seed));
    wb_single(DAT, RAM_BASE + 4, 1'b1, 4'hf, $random(seed));
    wb_single(DAT, 32'h8000_0400, 1'b1, 4'hf, $random(seed));
    wb_single(DAT, 32'h8000_0404, 1'b1, 4'hf, $random(seed));
    wb_single(DAT, 32'h8000_0400, 1'b0, 4'hf, '0);
    // Denied writes left both words alone
    wb_single(DAT, RAM_BASE, 1'b0, 4'hf, '0);
    wb_single(DAT, RAM_BASE + 4, 1'b0, 4'hf, '0);
    report_test("perm", e0);
  endtask

  task automatic test_ins_port();
    int              e0;
    logic [XLEN-1:0] rnd;
    e0 = n_errors;
    for (int i = 0; i < 4; i++) wb_single(INS, RAM_BASE + 4 * i, 1'b1, 4'hf, $random(seed));
    for (int i = 0; i < 4; i++) wb_single(INS, RAM_BASE + 4 * i, 1'b0, 4'hf, '0);
    // No execute in regions 3 and 1
    wb_single(INS, 32'h8000_0300, 1'b0, 4'hf, '0);
    wb_single(INS, 32'h8000_0200, 1'b0, 4'hf, '0);
    // Same address holds a different word in each RAM
    rnd = $random(seed);
    wb_single(DAT, RAM_BASE + 32'h40, 1'b1, 4'hf, rnd);
    wb_single(INS, RAM_BASE + 32'h40, 1'b1, 4'hf, ~rnd);
    wb_single(DAT, RAM_BASE + 32'h40, 1'b0, 4'hf, '0);
    wb_single(INS, RAM_BASE + 32'h40, 1'b0, 4'hf, '0);
    report_test("ins_port", e0);
  endtask

  task automatic test_bursts();
    int         e0;
    logic [1:0] modes [3];
    e0 = n_errors;
    modes = '{BTE_LINEAR, BTE_WRAP4, BTE_WRAP8};
    // Wrap-4 write from mid block and classic reads of the whole block
    for (int i = 0; i < 4; i++) beat_wdat[i] = $random(seed);
    wb_burst(DAT, RAM_BASE + 32'h108, BTE_WRAP4, 4, 1'b1, 4'hf, CTI_EOB);
    check_burst(DAT, 4, 1'b1);
    for (int i = 0; i < 4; i++) wb_single(DAT, RAM_BASE + 32'h100 + 4 * i, 1'b0, 4'hf, '0);
    foreach (modes[m]) begin
      wb_burst(DAT, RAM_BASE + 32'h108, modes[m], 8, 1'b0, 4'hf, CTI_EOB);
      check_burst(DAT, 8, 1'b0);
    end
    report_test("bursts", e0);
  endtask

  //////////////////////////////////////////////////
  // Run control
  //////////////////////////////////////////////////

  initial begin
    seed     = 32'hf15c3279;
    n_checks = 0;
    n_errors = 0;
    rst_n    = 1'b0;
    for (int p = 0; p < 2; p++) begin
      m_adr[p]  = '0;
      m_wdat[p] = '0;
      m_sel[p]  = '0;
      m_we[p]   = 1'b0;
      m_cyc[p]  = 1'b0;
      m_stb[p]  = 1'b0;
      m_cti[p]  = CTI_CLASSIC;
      m_bte[p]  = BTE_LINEAR;
    end
    repeat (RESET_CYC) @(posedge hclk);
    rst_n <= 1'b1;
    test_reset();
    test_byte_rw();
    test_perm();
    test_ins_port();
    test_bursts();
    // Gap check after the last response lands one edge later
    repeat (2) @(negedge hclk);
    // Failures counted by the bound assertion modules
    n_asserts = dut0.ins_guard.u_checks.fail_cnt + dut0.dat_guard.u_checks.fail_cnt;
    $display("Checks %0d, mismatches %0d, assertion failures %0d",
             n_checks, n_errors, n_asserts);
    if (n_errors == 0 && n_asserts == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge hclk);
      cycle_cnt++;
    end
    $display("Timeout: tests still running after %0d cycles", CYCLE_LIMIT);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/pu_mem_subsys_assertions.sv
/* Concurrent checks on the response of one guarded Wishbone port.
 * Bound into every wb_pma_guard instance.
 */

`default_nettype none

module wb_pma_guard_assertions (
  input logic       hclk_i,
  input logic       rst_n_i,
  input logic       cyc_i,
  input logic       stb_i,
  input logic [2:0] cti_i,
  input logic       ack_i,
  input logic       err_i
);

  timeunit 1ns;
  timeprecision 1ps;

  import pu_bus_pkg::*;

  // Read by the testbench at the end of the run
  int fail_cnt = 0;

  // Never both responses at once
  a_one_resp: assert property (@(posedge hclk_i) disable iff (!rst_n_i)
    !(ack_i && err_i))
    else begin
      fail_cnt++;
      $error("ack and err high in the same cycle");
    end

  // A response needs a strobe in the cycle before
  a_resp_after_stb: assert property (@(posedge hclk_i) disable iff (!rst_n_i)
    (ack_i || err_i) |-> $past(cyc_i && stb_i))
    else begin
      fail_cnt++;
      $error("response without a strobe in the previous cycle");
    end

  // Quiet bus when reset is released
  a_reset_low: assert property (@(posedge hclk_i)
    $rose(rst_n_i) |-> !ack_i && !err_i)
    else begin
      fail_cnt++;
      $error("response high right after reset");
    end

  // Classic and end-of-burst responses leave a gap
  a_classic_gap: assert property (@(posedge hclk_i) disable iff (!rst_n_i)
    (ack_i || err_i) && (cti_i != CTI_INCR) |=> !ack_i && !err_i)
    else begin
      fail_cnt++;
      $error("classic response not followed by a low cycle");
    end

endmodule

bind wb_pma_guard wb_pma_guard_assertions u_checks (
  .hclk_i  ( hclk_i  ),
  .rst_n_i ( rst_n_i ),
  .cyc_i   ( cyc_i   ),
  .stb_i   ( stb_i   ),
  .cti_i   ( cti_i   ),
  .ack_i   ( ack_o   ),
  .err_i   ( err_o   )
);

`default_nettype wire

//--- hdl/pu_mem_subsys.sv
/* Memory side of the processor top: a fetch port and a data port, each
 * with its own PMA guard and RAM. Driven by a core or a testbench master.
 */

`default_nettype none

module pu_mem_subsys #(
  parameter int DEPTH = 256
) (
  input  logic                         hclk_i,
  input  logic                         rst_n_i,

  // Instruction fetch port
  input  logic [pu_bus_pkg::PLEN-1:0]  ins_adr_i,
  input  logic [pu_bus_pkg::XLEN-1:0]  ins_dat_i,
  input  logic [pu_bus_pkg::SEL_W-1:0] ins_sel_i,
  input  logic                         ins_we_i,
  input  logic                         ins_cyc_i,
  input  logic                         ins_stb_i,
  input  logic [2:0]                   ins_cti_i,
  input  logic [1:0]                   ins_bte_i,
  output logic [pu_bus_pkg::XLEN-1:0]  ins_dat_o,
  output logic                         ins_ack_o,
  output logic                         ins_err_o,

  // Data port
  input  logic [pu_bus_pkg::PLEN-1:0]  dat_adr_i,
  input  logic [pu_bus_pkg::XLEN-1:0]  dat_dat_i,
  input  logic [pu_bus_pkg::SEL_W-1:0] dat_sel_i,
  input  logic                         dat_we_i,
  input  logic                         dat_cyc_i,
  input  logic                         dat_stb_i,
  input  logic [2:0]                   dat_cti_i,
  input  logic [1:0]                   dat_bte_i,
  output logic [pu_bus_pkg::XLEN-1:0]  dat_dat_o,
  output logic                         dat_ack_o,
  output logic                         dat_err_o
);

  //////////////////////////////////////////////////
  // Fetch side, reads need execute permission
  //////////////////////////////////////////////////

  wb_pma_guard #(
    .INS_PORT ( 1     ),
    .DEPTH    ( DEPTH )
  ) ins_guard (
    .hclk_i  ( hclk_i    ),
    .rst_n_i ( rst_n_i   ),
    .adr_i   ( ins_adr_i ),
    .dat_i   ( ins_dat_i ),
    .sel_i   ( ins_sel_i ),
    .we_i    ( ins_we_i  ),
    .cyc_i   ( ins_cyc_i ),
    .stb_i   ( ins_stb_i ),
    .cti_i   ( ins_cti_i ),
    .bte_i   ( ins_bte_i ),
    .dat_o   ( ins_dat_o ),
    .ack_o   ( ins_ack_o ),
    .err_o   ( ins_err_o )
  );

  //////////////////////////////////////////////////
  // Data side, reads need read permission
  //////////////////////////////////////////////////

  wb_pma_guard #(
    .INS_PORT ( 0     ),
    .DEPTH    ( DEPTH )
  ) dat_guard (
    .hclk_i  ( hclk_i    ),
    .rst_n_i ( rst_n_i   ),
    .adr_i   ( dat_adr_i ),
    .dat_i   ( dat_dat_i ),
    .sel_i   ( dat_sel_i ),
    .we_i    ( dat_we_i  ),
    .cyc_i   ( dat_cyc_i ),
    .stb_i   ( dat_stb_i ),
    .cti_i   ( dat_cti_i ),
    .bte_i   ( dat_bte_i ),
    .dat_o   ( dat_dat_o ),
    .ack_o   ( dat_ack_o ),
    .err_o   ( dat_err_o )
  );

endmodule

`default_nettype wire

//--- hdl/wb_pma_guard.sv
/* One Wishbone slave port guarded by a PMA check. Allowed accesses go to
 * the local RAM, denied ones get a one-cycle error and never reach it.
 */

`default_nettype none

module wb_pma_guard #(
  parameter int INS_PORT = 0,
  parameter int DEPTH    = 256
) (
  input  logic                         hclk_i,
  input  logic                         rst_n_i,
  input  logic [pu_bus_pkg::PLEN-1:0]  adr_i,
  input  logic [pu_bus_pkg::XLEN-1:0]  dat_i,
  input  logic [pu_bus_pkg::SEL_W-1:0] sel_i,
  input  logic                         we_i,
  input  logic                         cyc_i,
  input  logic                         stb_i,
  input  logic [2:0]                   cti_i,
  input  logic [1:0]                   bte_i,
  output logic [pu_bus_pkg::XLEN-1:0]  dat_o,
  output logic                         ack_o,
  output logic                         err_o
);

  // Region permissions for the address on the bus
  logic x_ok;
  logic r_ok;
  logic w_ok;
  logic allowed;
  logic valid;
  // Gated strobe towards the RAM
  logic ram_cyc;
  logic ram_stb;
  logic ram_ack;
  logic err_q;

  pma_check u_pma (
    .adr_i ( adr_i ),
    .x_o   ( x_ok  ),
    .r_o   ( r_ok  ),
    .w_o   ( w_ok  )
  );

  // Writes need w, fetches need x, data reads need r
  assign allowed = we_i ? w_ok : ((INS_PORT != 0) ? x_ok : r_ok);
  assign valid   = cyc_i & stb_i;

  // RAM never sees a denied access
  assign ram_cyc = cyc_i & allowed;
  assign ram_stb = stb_i & allowed;

  wb_spram #(
    .DEPTH ( DEPTH )
  ) u_ram (
    .hclk_i  ( hclk_i  ),
    .rst_n_i ( rst_n_i ),
    .adr_i   ( adr_i   ),
    .dat_i   ( dat_i   ),
    .sel_i   ( sel_i   ),
    .we_i    ( we_i    ),
    .cyc_i   ( ram_cyc ),
    .stb_i   ( ram_stb ),
    .cti_i   ( cti_i   ),
    .bte_i   ( bte_i   ),
    .dat_o   ( dat_o   ),
    .ack_o   ( ram_ack )
  );

  // Burst stepping into a denied region loses its early ack
  assign ack_o = ram_ack & allowed;

  // Error pulse, same spacing as a classic ack
  always_ff @(posedge hclk_i) begin
    if (!rst_n_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= valid & ~allowed & ~err_q;
    end
  end

  assign err_o = err_q;

endmodule

`default_nettype wire

//--- hdl/wb_spram.sv
/* Wishbone single-port RAM with byte selects, classic cycles and
 * incrementing bursts with linear or wrapped address sequencing.
 */

`default_nettype none

module wb_spram #(
  parameter int DEPTH = 256
) (
  input  logic                         hclk_i,
  input  logic                         rst_n_i,
  input  logic [pu_bus_pkg::PLEN-1:0]  adr_i,
  input  logic [pu_bus_pkg::XLEN-1:0]  dat_i,
  input  logic [pu_bus_pkg::SEL_W-1:0] sel_i,
  input  logic                         we_i,
  input  logic                         cyc_i,
  input  logic                         stb_i,
  input  logic [2:0]                   cti_i,
  input  logic [1:0]                   bte_i,
  output logic [pu_bus_pkg::XLEN-1:0]  dat_o,
  output logic                         ack_o
);

  import pu_bus_pkg::*;

  // Word index width, DEPTH is a power of two
  localparam int IDX_W = $clog2(DEPTH);

  // Storage, cleared at power up
  logic [XLEN-1:0]  mem [DEPTH] = '{default: '0};
  // Index of the beat on the bus
  logic [IDX_W-1:0] cur_idx;
  // Index the read data comes from
  logic [IDX_W-1:0] rd_idx_q;
  logic             valid;
  logic             burst_go;
  logic             wr_en;
  logic             ack_q;

  // Next word in a burst, wrapped inside a 4, 8 or 16 word block
  function automatic logic [IDX_W-1:0] next_idx(input logic [IDX_W-1:0] idx,
                                                input logic [1:0]       bte);
    logic [IDX_W-1:0] inc;
    inc = idx + 1'b1;
    case (bte)
      BTE_LINEAR: next_idx = inc;
      BTE_WRAP4:  next_idx = {idx[IDX_W-1:2], inc[1:0]};
      BTE_WRAP8:  next_idx = {idx[IDX_W-1:3], inc[2:0]};
      BTE_WRAP16: next_idx = {idx[IDX_W-1:4], inc[3:0]};
    endcase
  endfunction

  assign valid   = cyc_i & stb_i;
  // Address bits above the byte offset, modulo DEPTH
  assign cur_idx = adr_i[IDX_W+1:2];

  // Current beat completes now and another one follows
  assign burst_go = valid & ack_q & (cti_i == CTI_INCR);

  //////////////////////////////////////////////////
  // Acknowledge
  //////////////////////////////////////////////////

  // First beat acked one cycle after strobe
  // Classic and EOB drop for a cycle, INCR keeps it up
  always_ff @(posedge hclk_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= valid & (~ack_q | burst_go);
    end
  end

  assign ack_o = ack_q;

  //////////////////////////////////////////////////
  // Read address
  //////////////////////////////////////////////////

  // Bus still shows the acked beat, so step ahead here
  always_ff @(posedge hclk_i) begin
    if (valid) begin
      rd_idx_q <= burst_go ? next_idx(cur_idx, bte_i) : cur_idx;
    end
  end

  assign dat_o = mem[rd_idx_q];

  //////////////////////////////////////////////////
  // Write port
  //////////////////////////////////////////////////

  // Written at the edge the beat completes
  assign wr_en = valid & ack_q & we_i;

  always_ff @(posedge hclk_i) begin
    if (wr_en) begin
      for (int b = 0; b < SEL_W; b++) begin
        // Only lanes with sel set
        if (sel_i[b]) begin
          mem[cur_idx][8*b +: 8] <= dat_i[8*b +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/pma_check.sv
/* Combinational PMA lookup. Matches a byte address against the region
 * table and returns execute, read and write permission of the first hit.
 */

`default_nettype none

module pma_check (
  input  logic [pu_bus_pkg::PLEN-1:0] adr_i,
  output logic                        x_o,
  output logic                        r_o,
  output logic                        w_o
);

  import pu_bus_pkg::*;
  import pu_pma_pkg::*;

  // Word address, same scale as the table
  logic [PLEN-1:0]    word_adr;
  // One hit flag per region
  logic [PMA_CNT-1:0] hit;
  // Attributes of the winning region
  logic [7:0]         attr;

  assign word_adr = adr_i >> 2;

  //////////////////////////////////////////////////
  // Per-region match
  //////////////////////////////////////////////////

  for (genvar i = 0; i < PMA_CNT; i++) begin : gen_region
    // Upper bound, or the word itself for NA4 and NAPOT
    localparam logic [PLEN-1:0] TOP = PMA_ADR[i];
    // TOR lower bound, zero for the first entry
    localparam logic [PLEN-1:0] BOT = (i == 0) ? '0 : PMA_ADR[(i == 0) ? 0 : i - 1];
    // Trailing ones plus one bit give the ignored low bits
    localparam logic [PLEN-1:0] IGN = TOP ^ (TOP + 1'b1);

    logic hit_r;

    always_comb begin
      case (PMA_CFG[i].mode)
        MATCH_OFF:   hit_r = 1'b0;
        MATCH_TOR:   hit_r = (word_adr >= BOT) && (word_adr < TOP);
        MATCH_NA4:   hit_r = (word_adr == TOP);
        MATCH_NAPOT: hit_r = ((word_adr ^ TOP) & ~IGN) == '0;
      endcase
    end

    assign hit[i] = hit_r;
  end

  //////////////////////////////////////////////////
  // Priority select
  //////////////////////////////////////////////////

  // Walk downwards so the lowest index is written last
  // No hit leaves everything denied
  always_comb begin
    attr = '0;
    for (int i = PMA_CNT - 1; i >= 0; i--) begin
      if (hit[i]) begin
        attr = PMA_CFG[i].attr;
      end
    end
  end

  assign x_o = attr[ATTR_X];
  assign r_o = attr[ATTR_R];
  assign w_o = attr[ATTR_W];

endmodule

`default_nettype wire

//--- hdl/pu_pma_pkg.sv
/* Physical memory attribute encodings and the fixed four-region table.
 * Read by pma_check; the lowest matching region wins.
 */

`default_nettype none

package pu_pma_pkg;

  // Number of regions in the table
  localparam int PMA_CNT = 4;

  //////////////////////////////////////////////////
  // Address match modes
  //////////////////////////////////////////////////

  // Region disabled
  localparam logic [1:0] MATCH_OFF   = 2'b00;
  // Top of range, bottom taken from the previous entry
  localparam logic [1:0] MATCH_TOR   = 2'b01;
  // Single naturally aligned word
  localparam logic [1:0] MATCH_NA4   = 2'b10;
  // Power-of-two block, size coded by trailing ones
  localparam logic [1:0] MATCH_NAPOT = 2'b11;

  // Memory types
  localparam logic [1:0] MEM_MAIN = 2'b00;
  localparam logic [1:0] MEM_IO   = 2'b01;

  // Bit positions in the attribute byte
  // Lower bits hold cacheable and idempotent flags, not checked here
  localparam int ATTR_X = 7;
  localparam int ATTR_R = 6;
  localparam int ATTR_W = 5;

  // Configuration word, 14 bits
  typedef struct packed {
    logic [1:0] mem_type;
    logic [7:0] attr;
    // AMO class, carried along
    logic [1:0] amo;
    logic [1:0] mode;
  } pma_cfg_t;

  //////////////////////////////////////////////////
  // Region table
  //////////////////////////////////////////////////

  // Type, attributes (x r w c ...), amo, match mode
  localparam pma_cfg_t PMA_CFG [PMA_CNT] = '{
    '{MEM_MAIN, 8'b1111_1000, 2'b00, MATCH_TOR},
    '{MEM_IO,   8'b0110_0000, 2'b00, MATCH_NAPOT},
    '{MEM_IO,   8'b0010_0000, 2'b00, MATCH_NA4},
    '{MEM_MAIN, 8'b0111_1000, 2'b00, MATCH_TOR}
  };

  // Word addresses, byte address shifted right by 2
  // Entry 1 has one trailing one, so 4 words
  localparam logic [pu_bus_pkg::PLEN-1:0] PMA_ADR [PMA_CNT] = '{
    (pu_bus_pkg::RAM_BASE + 32'h200) >> 2,
    ((pu_bus_pkg::RAM_BASE + 32'h200) >> 2) | 32'h1,
    (pu_bus_pkg::RAM_BASE + 32'h210) >> 2,
    (pu_bus_pkg::RAM_BASE + 32'h400) >> 2
  };

endpackage

`default_nettype wire

//--- hdl/pu_bus_pkg.sv
/* Bus widths and Wishbone cycle and burst codes shared by the memory
 * subsystem. Modules import it in their body and use scoped names in ports.
 */

`default_nettype none

package pu_bus_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  // Data word
  localparam int XLEN  = 32;
  // Physical address
  localparam int PLEN  = 32;
  // One select bit per byte lane
  localparam int SEL_W = XLEN / 8;

  //////////////////////////////////////////////////
  // Wishbone cycle type identifiers (cti)
  //////////////////////////////////////////////////

  localparam logic [2:0] CTI_CLASSIC = 3'b000;
  localparam logic [2:0] CTI_INCR    = 3'b010;
  // Last beat of a burst
  localparam logic [2:0] CTI_EOB     = 3'b111;

  //////////////////////////////////////////////////
  // Wishbone burst type extensions (bte)
  //////////////////////////////////////////////////

  localparam logic [1:0] BTE_LINEAR = 2'b00;
  localparam logic [1:0] BTE_WRAP4  = 2'b01;
  localparam logic [1:0] BTE_WRAP8  = 2'b10;
  localparam logic [1:0] BTE_WRAP16 = 2'b11;

  // Start of the on-chip RAM window
  localparam logic [PLEN-1:0] RAM_BASE = 32'h8000_0000;

endpackage

`default_nettype wire
